/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module tb_rv_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

/* rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// architectural data width
`define RV_XLEN 32

// integer register file
`define RV_REG_COUNT 32
`define RV_REG_ADDR_W 5

`endif

/* rv_core_pkg.sv */
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

    // data word and register index
    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes handled by the core, everything else is a bubble
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // lui, result is operand b
        ALU_PASS_B
    } alu_op_t;

    // operand b source
    typedef enum logic {
        B_SEL_RS2 = 1'b0,
        B_SEL_IMM = 1'b1
    } b_sel_t;

endpackage

`default_nettype wire

/* rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid_i,
    input  rv_core_pkg::xlen_t     inst_i,
    output logic                   retire_o,
    output rv_core_pkg::reg_addr_t retire_rd_o,
    output rv_core_pkg::xlen_t     retire_data_o
);

    dec_exe_if dec_exe ();
    exe_ret_if exe_ret ();

    // retire outputs double as the writeback bus
    rv_decode rv_decode_i (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_i   (retire_o),
        .wb_rd_i      (retire_rd_o),
        .wb_data_i    (retire_data_o),
        .out          (dec_exe.dec)
    );

    rv_execute rv_execute_i (
        .clk        (clk),
        .rst        (rst),
        .in         (dec_exe.exe),
        .wb_valid_i (retire_o),
        .wb_rd_i    (retire_rd_o),
        .wb_data_i  (retire_data_o),
        .out        (exe_ret.exe)
    );

    rv_retire rv_retire_i (
        .clk        (clk),
        .rst        (rst),
        .in         (exe_ret.ret),
        .wb_valid_o (retire_o),
        .wb_rd_o    (retire_rd_o),
        .wb_data_o  (retire_data_o)
    );

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid_i,
    input  rv_core_pkg::xlen_t     inst_i,
    input  logic                   wb_valid_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    input  rv_core_pkg::xlen_t     wb_data_i,
    dec_exe_if.dec                 out
);
    import rv_core_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       supported;
    logic       use_rs1;
    logic       use_rs2;
    alu_op_t    alu_op;
    b_sel_t     b_sel;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      rs1_data;
    xlen_t      rs2_data;

    // funct3 to alu op, sub only exists in the register form
    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt,
                                               input logic is_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ----------------------------------------------------------
    // field decode
    assign opcode    = opcode_t'(inst_i[6:0]);
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];

    always_comb begin
        supported = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b0;
        alu_op    = ALU_ADD;
        b_sel     = B_SEL_RS2;
        case (opcode)
            OPC_OP: begin
                use_rs2 = 1'b1;
                alu_op  = alu_from_funct(funct3, funct7_b5, 1'b1);
            end
            OPC_OP_IMM: begin
                b_sel  = B_SEL_IMM;
                alu_op = alu_from_funct(funct3, funct7_b5, 1'b0);
            end
            OPC_LUI: begin
                use_rs1 = 1'b0;
                b_sel   = B_SEL_IMM;
                alu_op  = ALU_PASS_B;
            end
            default: begin
                supported = 1'b0;
                use_rs1   = 1'b0;
            end
        endcase
    end

    // unused sources read as x0, so lui gets op_a of zero
    assign rs1 = use_rs1 ? inst_i[19:15] : '0;
    assign rs2 = use_rs2 ? inst_i[24:20] : '0;

    assign imm_i = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};

    rv_reg_file rv_reg_file_i (
        .clk         (clk),
        .rd_addr_a_i (rs1),
        .rd_addr_b_i (rs2),
        .rd_data_a_o (rs1_data),
        .rd_data_b_o (rs2_data),
        .we_i        (wb_valid_i),
        .wr_addr_i   (wb_rd_i),
        .wr_data_i   (wb_data_i)
    );

    // ----------------------------------------------------------
    // decode/execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= inst_valid_i && supported;
        end
    end

    always_ff @(posedge clk) begin
        out.alu_op <= alu_op;
        out.b_sel  <= b_sel;
        out.op_a   <= rs1_data;
        if (b_sel == B_SEL_IMM) begin
            out.op_b <= (opcode == OPC_LUI) ? imm_u : imm_i;
        end else begin
            out.op_b <= rs2_data;
        end
        out.rs1 <= rs1;
        out.rs2 <= rs2;
        out.rd  <= inst_i[11:7];
    end

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic                   clk,
    input  logic                   rst,
    dec_exe_if.exe                 in,
    input  logic                   wb_valid_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    input  rv_core_pkg::xlen_t     wb_data_i,
    exe_ret_if.exe                 out
);
    import rv_core_pkg::*;

    logic       exe_hit_a;
    logic       exe_hit_b;
    logic       wb_hit_a;
    logic       wb_hit_b;
    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      result;
    logic [4:0] shamt;

    // ----------------------------------------------------------
    // operand forwarding
    // previous instruction still sits in our own output register,
    // the one before it is in retire; the younger one wins
    assign exe_hit_a = out.valid && (out.rd != '0) && (out.rd == in.rs1);
    assign exe_hit_b = out.valid && (out.rd != '0) && (out.rd == in.rs2)
                       && (in.b_sel == B_SEL_RS2);
    assign wb_hit_a  = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == in.rs1);
    assign wb_hit_b  = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == in.rs2)
                       && (in.b_sel == B_SEL_RS2);

    assign op_a = exe_hit_a ? out.result : (wb_hit_a ? wb_data_i : in.op_a);
    assign op_b = exe_hit_b ? out.result : (wb_hit_b ? wb_data_i : in.op_b);

    // ----------------------------------------------------------
    // alu
    assign shamt = op_b[4:0];

    always_comb begin
        case (in.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   result = xlen_t'(op_a < op_b);
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = xlen_t'($signed(op_a) >>> shamt);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // execute/retire register
    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        out.rd     <= in.rd;
        out.result <= result;
    end

endmodule

`default_nettype wire

/* rv_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_reg_file (
    input  logic                   clk,
    input  rv_core_pkg::reg_addr_t rd_addr_a_i,
    input  rv_core_pkg::reg_addr_t rd_addr_b_i,
    output rv_core_pkg::xlen_t     rd_data_a_o,
    output rv_core_pkg::xlen_t     rd_data_b_o,
    input  logic                   we_i,
    input  rv_core_pkg::reg_addr_t wr_addr_i,
    input  rv_core_pkg::xlen_t     wr_data_i
);
    import rv_core_pkg::*;

    xlen_t regs [`RV_REG_COUNT];
    logic  wr_en;
    logic  hit_a;
    logic  hit_b;

    // x0 is never written
    assign wr_en = we_i && (wr_addr_i != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through, same-cycle write is visible to the reader
    assign hit_a = wr_en && (wr_addr_i == rd_addr_a_i);
    assign hit_b = wr_en && (wr_addr_i == rd_addr_b_i);

    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 :
                         (hit_a ? wr_data_i : regs[rd_addr_a_i]);
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 :
                         (hit_b ? wr_data_i : regs[rd_addr_b_i]);

endmodule

`default_nettype wire

/* rv_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_retire (
    input  logic                   clk,
    input  logic                   rst,
    exe_ret_if.ret                 in,
    output logic                   wb_valid_o,
    output rv_core_pkg::reg_addr_t wb_rd_o,
    output rv_core_pkg::xlen_t     wb_data_o
);

    // retire register, also the register file write port
    // and the forwarding source for execute
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= in.valid;
        end
    end

    // rd of zero still retires, the register file drops the write
    always_ff @(posedge clk) begin
        wb_rd_o   <= in.rd;
        wb_data_o <= in.result;
    end

endmodule

`default_nettype wire

/* rv_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// ----------------------------------------------------------
// decode -> execute
interface dec_exe_if;
    import rv_core_pkg::*;

    logic      valid;
    alu_op_t   alu_op;
    xlen_t     op_a;
    xlen_t     op_b;
    b_sel_t    b_sel;
    // zero when the operand is not a register
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;

    modport dec (output valid, alu_op, op_a, op_b, b_sel, rs1, rs2, rd);
    modport exe (input valid, alu_op, op_a, op_b, b_sel, rs1, rs2, rd);
endinterface

// ----------------------------------------------------------
// execute -> retire
interface exe_ret_if;
    import rv_core_pkg::*;

    logic      valid;
    reg_addr_t rd;
    xlen_t     result;

    modport exe (output valid, rd, result);
    modport ret (input valid, rd, result);
endinterface

`default_nettype wire

/* tb.f */
+incdir+.
rv_core_pkg.sv
rv_stage_if.sv
rv_reg_file.sv
rv_decode.sv
rv_execute.sv
rv_retire.sv
rv_core_top.sv
tb_rv_core.sv

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module tb_rv_core;

    typedef struct packed {
        logic                      valid;
        logic [`RV_XLEN-1:0]       inst;
        logic                      expect_retire;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       data;
    } stim_t;

    // expected retire and the cycle it must show up in
    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       data;
        logic [31:0]               cycle;
    } retire_exp_t;

    logic                      clk;
    logic                      rst;
    logic                      inst_valid_i;
    logic [`RV_XLEN-1:0]       inst_i;
    logic                      retire_o;
    logic [`RV_REG_ADDR_W-1:0] retire_rd_o;
    logic [`RV_XLEN-1:0]       retire_data_o;

    stim_t       stim_q [$];
    retire_exp_t exp_q [$];
    int          cycle_cnt;
    int          cycle_limit;
    int          mismatch_cnt;
    int          other_cnt;

    rv_core_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .retire_o      (retire_o),
        .retire_rd_o   (retire_rd_o),
        .retire_data_o (retire_data_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at time %0t: %s got 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
        end
    endtask

    // lines that do not parse as five fields are comments
    task automatic read_stim();
        int          fd;
        int          n;
        string       line;
        stim_t       s;
        logic [31:0] v;
        logic [31:0] inst;
        logic [31:0] flag;
        logic [31:0] rd;
        logic [31:0] data;
        fd = $fopen("tb_rv_core_stim.txt", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("could not open the stimulus file tb_rv_core_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %d %h", v, inst, flag, rd, data);
            if (n == 5) begin
                s.valid         = v[0];
                s.inst          = inst;
                s.expect_retire = flag[0];
                s.rd            = rd[`RV_REG_ADDR_W-1:0];
                s.data          = data;
                stim_q.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------
    // stimulus
    initial begin
        stim_t       s;
        retire_exp_t e;
        int          idle;
        void'($urandom(20894));
        clk          = 1'b0;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        cycle_cnt    = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        read_stim();
        cycle_limit = stim_q.size() * 4 + 50;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (stim_q[i]) begin
            s = stim_q[i];
            if (!s.valid) begin
                // gap between groups
                idle = $urandom % 3;
                inst_valid_i = 1'b0;
                repeat (idle) begin
                    @(posedge clk);
                    #1;
                end
            end else begin
                inst_valid_i = 1'b1;
                inst_i       = s.inst;
                if (s.expect_retire) begin
                    // accepted on the next edge and retired two edges later
                    e.rd    = s.rd;
                    e.data  = s.data;
                    e.cycle = cycle_cnt + 3;
                    exp_q.push_back(e);
                end
                @(posedge clk);
                #1;
            end
        end
        inst_valid_i = 1'b0;
        inst_i       = '0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // catch any stray retire after the last one
        repeat (4) @(posedge clk);

        $display("errors: %0d (mismatches %0d, other %0d)",
                 mismatch_cnt + other_cnt, mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // ----------------------------------------------------------
    // retire monitor samples mid-cycle
    always @(negedge clk) begin
        retire_exp_t e;
        if (rst) begin
            if (cycle_cnt > 0) begin
                check_value("retire_o", {31'b0, retire_o}, 32'd0);
            end
        end else if (retire_o) begin
            if (exp_q.size() == 0) begin
                other_cnt++;
                $display("retire at time %0t with no instruction outstanding (rd %0d)",
                         $time, retire_rd_o);
            end else begin
                e = exp_q.pop_front();
                check_value("retire_rd_o", {27'b0, retire_rd_o}, {27'b0, e.rd});
                check_value("retire_data_o", retire_data_o, e.data);
                check_value("retire cycle", cycle_cnt, e.cycle);
            end
        end
    end

    initial begin
        wait (cycle_limit != 0);
        wait (cycle_cnt >= cycle_limit);
        $display("timeout after %0d cycles, %0d retires never arrived, errors: %0d",
                 cycle_cnt, exp_q.size(), mismatch_cnt + other_cnt + 1);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_rv_core_stim.txt */
// valid instruction(hex) expect_retire rd(dec) result(hex); a valid of 0 is a 0 to 2 cycle gap
1 800000B7 1 1 80000000
1 FFB00113 1 2 FFFFFFFB
1 12300193 1 3 00000123
1 12345237 1 4 12345000
1 67826213 1 4 12345678
1 003202B3 1 5 1234579B
1 40218333 1 6 00000128
1 002193B3 1 7 18000000
1 00312433 1 8 00000001
1 003134B3 1 9 00000000
1 00224533 1 10 EDCBA983
1 0030D5B3 1 11 10000000
1 4030D633 1 12 F0000000
1 003266B3 1 13 1234577B
1 00327733 1 14 00000020
0 00000000 0 0 00000000
1 00700793 1 15 00000007
1 00479813 1 16 00000070
1 40F808B3 1 17 00000069
1 01178933 1 18 00000070
1 40115993 1 19 FFFFFFFD
1 FFE9AA13 1 20 00000001
1 FFF24B13 1 22 EDCBA987
0 00000000 0 0 00000000
1 05518013 1 0 00000178
1 00300CB3 1 25 00000123
1 0030A023 0 0 00000000
1 00000D33 1 26 00000000
1 00208463 0 0 00000000
1 419D0DB3 1 27 FFFFFEDD
